// File: source/dma_defines.svh
//------------------------------
// width, depth and opcode constants of the DMA front end
// included by the package and by modules that size storage
//------------------------------
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

`define DMA_ADDR_W      32
`define DMA_DATA_W      32
`define DMA_ID_W        32
`define DMA_REP_W       32
`define DMA_TAG_W       5
`define DMA_FIFO_DEPTH  3
// opcode field, codes above OP_STAT are unknown
`define DMA_OP_W        3
`define DMA_WORD_BYTES  4

`endif

// File: source/dma_pkg.sv
//------------------------------
// shared types of the DMA front end
// imported by every module and by the testbench
//------------------------------
`include "dma_defines.svh"
`default_nettype none

package dma_pkg;

    typedef logic [`DMA_ADDR_W-1:0] addr_t;
    typedef logic [`DMA_DATA_W-1:0] data_t;
    typedef logic [`DMA_ID_W-1:0]   tf_id_t;
    typedef logic [`DMA_REP_W-1:0]  rep_t;
    typedef logic [`DMA_TAG_W-1:0]  tag_t;

    // encoded 0 to 5, codes 6 and 7 are unknown
    typedef enum logic [`DMA_OP_W-1:0] {
        OP_SRC,
        OP_DST,
        OP_STR,
        OP_REP,
        OP_CPY,
        OP_STAT
    } dma_op_e;

    //------------------------------
    // accelerator port
    //------------------------------
    typedef struct packed {
        tag_t    tag;
        dma_op_e op;
        data_t   arg_a;
        data_t   arg_b;
    } acc_req_t;

    typedef struct packed {
        tag_t  tag;
        data_t data;
        logic  error;
    } acc_rsp_t;

    // one copy job, length in bytes
    typedef struct packed {
        addr_t src;
        addr_t dst;
        rep_t  length;
        rep_t  reps;
        rep_t  src_stride;
        rep_t  dst_stride;
    } dma_job_t;

    //------------------------------
    // wishbone classic
    //------------------------------
    typedef struct packed {
        logic                       cyc;
        logic                       stb;
        logic                       we;
        addr_t                      adr;
        data_t                      dat;
        logic [`DMA_WORD_BYTES-1:0] sel;
    } wb_m2s_t;

    typedef struct packed {
        logic  ack;
        data_t dat;
    } wb_s2m_t;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE,
        NEXT
    } eng_state_e;

endpackage

`default_nettype wire

// File: source/dma_cfg_regs.sv
//------------------------------
// configuration registers and transfer-id counters
// written by the decoder strobes, counts issued and retired jobs
//------------------------------
`default_nettype none

module dma_cfg_regs import dma_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    input  wire logic     wr_src_i,
    input  wire logic     wr_dst_i,
    input  wire logic     wr_str_i,
    input  wire logic     wr_rep_i,
    input  wire data_t    arg_a_i,
    input  wire data_t    arg_b_i,
    input  wire logic     issue_i,
    input  wire logic     retire_i,
    output dma_job_t      cfg_o,
    output tf_id_t        next_id_o,
    output tf_id_t        completed_id_o
);

    dma_job_t cfg_q;
    tf_id_t   next_id_q;
    tf_id_t   completed_id_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg_q          <= '0;
            next_id_q      <= tf_id_t'(1);
            completed_id_q <= '0;
        end else begin
            if (wr_src_i) cfg_q.src <= arg_a_i;
            if (wr_dst_i) cfg_q.dst <= arg_a_i;
            if (wr_str_i) begin
                cfg_q.src_stride <= arg_a_i;
                cfg_q.dst_stride <= arg_b_i;
            end
            if (wr_rep_i) cfg_q.reps <= arg_a_i;
            if (issue_i)  next_id_q <= next_id_q + tf_id_t'(1);
            if (retire_i) completed_id_q <= completed_id_q + tf_id_t'(1);
        end
    end

    // length comes from the copy op itself
    always_comb begin
        cfg_o        = cfg_q;
        cfg_o.length = '0;
    end

    assign next_id_o      = next_id_q;
    assign completed_id_o = completed_id_q;

    // engine can only retire jobs the decoder has issued
    a_retire_after_issue: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        completed_id_q < next_id_q);

endmodule

`default_nettype wire

// File: source/dma_inst_decode.sv
//------------------------------
// decodes accelerator requests into register writes, jobs and responses
// purely combinational, sits between the port, cfg regs and queue
//------------------------------
`default_nettype none

module dma_inst_decode import dma_pkg::*; (
    input  wire acc_req_t acc_req_i,
    input  wire logic     acc_req_valid_i,
    input  wire dma_job_t cfg_i,
    input  wire tf_id_t   next_id_i,
    input  wire tf_id_t   completed_id_i,
    input  wire logic     busy_i,
    input  wire logic     job_ready_i,
    input  wire logic     rsp_ready_i,
    output logic          acc_req_ready_o,
    output logic          wr_src_o,
    output logic          wr_dst_o,
    output logic          wr_str_o,
    output logic          wr_rep_o,
    output data_t         arg_a_o,
    output data_t         arg_b_o,
    output logic          issue_o,
    output dma_job_t      job_o,
    output logic          job_valid_o,
    output acc_rsp_t      rsp_o,
    output logic          rsp_valid_o
);

    assign arg_a_o = acc_req_i.arg_a;
    assign arg_b_o = acc_req_i.arg_b;

    // job from stored config, one row unless 2-D is requested
    always_comb begin
        job_o        = cfg_i;
        job_o.length = acc_req_i.arg_a;
        if (!acc_req_i.arg_b[1]) job_o.reps = rep_t'(1);
    end

    always_comb begin
        acc_req_ready_o = 1'b0;
        wr_src_o        = 1'b0;
        wr_dst_o        = 1'b0;
        wr_str_o        = 1'b0;
        wr_rep_o        = 1'b0;
        issue_o         = 1'b0;
        job_valid_o     = 1'b0;
        rsp_valid_o     = 1'b0;
        // unknown ops answer with the error flag
        rsp_o           = '{tag: acc_req_i.tag, data: '0, error: 1'b1};

        if (acc_req_valid_i) begin
            case (acc_req_i.op)
                OP_SRC: begin
                    wr_src_o        = 1'b1;
                    acc_req_ready_o = 1'b1;
                end
                OP_DST: begin
                    wr_dst_o        = 1'b1;
                    acc_req_ready_o = 1'b1;
                end
                OP_STR: begin
                    wr_str_o        = 1'b1;
                    acc_req_ready_o = 1'b1;
                end
                OP_REP: begin
                    wr_rep_o        = 1'b1;
                    acc_req_ready_o = 1'b1;
                end
                OP_CPY: begin
                    // needs room in both the skid buffer and the queue
                    job_valid_o = rsp_ready_i;
                    rsp_o.data  = next_id_i;
                    rsp_o.error = 1'b0;
                    if (rsp_ready_i && job_ready_i) begin
                        issue_o         = 1'b1;
                        rsp_valid_o     = 1'b1;
                        acc_req_ready_o = 1'b1;
                    end
                end
                OP_STAT: begin
                    rsp_o.error = 1'b0;
                    case (acc_req_i.arg_b[1:0])
                        2'd0:    rsp_o.data = completed_id_i;
                        2'd1:    rsp_o.data = next_id_i;
                        2'd2:    rsp_o.data = data_t'(busy_i);
                        default: rsp_o.data = data_t'(!job_ready_i);
                    endcase
                    rsp_valid_o     = rsp_ready_i;
                    acc_req_ready_o = rsp_ready_i;
                end
                default: begin
                    rsp_valid_o     = rsp_ready_i;
                    acc_req_ready_o = rsp_ready_i;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/dma_job_fifo.sv
//------------------------------
// circular queue of pending copy jobs
// filled by the decoder, drained by the copy engine
//------------------------------
`include "dma_defines.svh"
`default_nettype none

module dma_job_fifo import dma_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    input  wire dma_job_t push_i,
    input  wire logic     push_valid_i,
    output logic          push_ready_o,
    output dma_job_t      pop_o,
    output logic          pop_valid_o,
    input  wire logic     pop_ready_i,
    output logic          empty_o
);

    localparam int unsigned DEPTH = `DMA_FIFO_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    dma_job_t           mem_q [DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic               push, pop, full;

    assign full         = (count_q == CNT_W'(DEPTH));
    assign empty_o      = (count_q == '0);
    assign push_ready_o = !full;
    assign pop_valid_o  = !empty_o;
    assign pop_o        = mem_q[rd_ptr_q];
    assign push         = push_valid_i && push_ready_o;
    assign pop          = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (pop)  rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) mem_q[wr_ptr_q] <= push_i;
    end

    // a push while full would overwrite the head entry
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (full && !pop) |=> $stable(pop_o));

endmodule

`default_nettype wire

// File: source/dma_copy_engine.sv
//------------------------------
// runs one job at a time as 1-D or 2-D word copies
// one wishbone read then one write per word
//------------------------------
`include "dma_defines.svh"
`default_nettype none

module dma_copy_engine import dma_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    input  wire dma_job_t job_i,
    input  wire logic     job_valid_i,
    output logic          job_ready_o,
    output wb_m2s_t       wb_m2s_o,
    input  wire wb_s2m_t  wb_s2m_i,
    output logic          retire_o,
    output logic          busy_o
);

    localparam int unsigned WORD_SHIFT = $clog2(`DMA_WORD_BYTES);

    eng_state_e state_q;
    dma_job_t   job_q;
    rep_t       rep_idx_q, word_idx_q;
    addr_t      src_row_q, dst_row_q;
    data_t      data_q;
    rep_t       num_words;
    addr_t      word_off;
    logic       last_row;

    assign num_words   = job_q.length >> WORD_SHIFT;
    assign word_off    = addr_t'(word_idx_q << WORD_SHIFT);
    // zero words or zero reps end the job at the first row check
    assign last_row    = (num_words == '0) || (rep_idx_q + rep_t'(1) >= job_q.reps);
    assign job_ready_o = (state_q == IDLE);
    assign busy_o      = (state_q != IDLE);
    assign retire_o    = (state_q == NEXT) && last_row;

    // bus outputs
    always_comb begin
        wb_m2s_o     = '0;
        wb_m2s_o.sel = '1;
        wb_m2s_o.cyc = (state_q == READ) || (state_q == WRITE);
        wb_m2s_o.stb = wb_m2s_o.cyc;
        wb_m2s_o.we  = (state_q == WRITE);
        wb_m2s_o.adr = (state_q == WRITE) ? dst_row_q + word_off : src_row_q + word_off;
        wb_m2s_o.dat = data_q;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            rep_idx_q  <= '0;
            word_idx_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    rep_idx_q  <= '0;
                    word_idx_q <= '0;
                    if (job_valid_i) begin
                        state_q <= ((job_i.length >> WORD_SHIFT) == '0 || job_i.reps == '0)
                                   ? NEXT : READ;
                    end
                end
                READ: if (wb_s2m_i.ack) state_q <= WRITE;
                WRITE: begin
                    if (wb_s2m_i.ack) begin
                        if (word_idx_q + rep_t'(1) == num_words) begin
                            state_q <= NEXT;
                        end else begin
                            word_idx_q <= word_idx_q + rep_t'(1);
                            state_q    <= READ;
                        end
                    end
                end
                NEXT: begin
                    if (last_row) begin
                        state_q <= IDLE;
                    end else begin
                        rep_idx_q  <= rep_idx_q + rep_t'(1);
                        word_idx_q <= '0;
                        state_q    <= READ;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // job copy, row bases and read data
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && job_valid_i) begin
            job_q     <= job_i;
            src_row_q <= job_i.src;
            dst_row_q <= job_i.dst;
        end
        if (state_q == NEXT && !last_row) begin
            src_row_q <= src_row_q + job_q.src_stride;
            dst_row_q <= dst_row_q + job_q.dst_stride;
        end
        if (state_q == READ && wb_s2m_i.ack) data_q <= wb_s2m_i.dat;
    end

    // strobe held with cyc and a stable address until the slave acks
    a_stb_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wb_m2s_o.stb && !wb_s2m_i.ack) |=>
            (wb_m2s_o.stb && wb_m2s_o.cyc && $stable(wb_m2s_o.adr)));

endmodule

`default_nettype wire

// File: source/dma_rsp_skid.sv
//------------------------------
// two-entry response buffer with a registered ready
// keeps the request side off the response back-pressure path
//------------------------------
`default_nettype none

module dma_rsp_skid import dma_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    input  wire acc_rsp_t in_i,
    input  wire logic     in_valid_i,
    output logic          in_ready_o,
    output acc_rsp_t      out_o,
    output logic          out_valid_o,
    input  wire logic     out_ready_i
);

    acc_rsp_t   slot_q [2];
    logic       wr_ptr_q, rd_ptr_q;
    logic [1:0] count_q, count_d;
    logic       ready_q, push, pop;

    assign push        = in_valid_i && ready_q;
    assign pop         = out_valid_o && out_ready_i;
    assign count_d     = count_q + 2'(push) - 2'(pop);
    assign in_ready_o  = ready_q;
    assign out_valid_o = (count_q != 2'd0);
    assign out_o       = slot_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
            ready_q  <= 1'b0;
        end else begin
            if (push) wr_ptr_q <= !wr_ptr_q;
            if (pop)  rd_ptr_q <= !rd_ptr_q;
            count_q <= count_d;
            ready_q <= (count_d != 2'd2);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) slot_q[wr_ptr_q] <= in_i;
    end

endmodule

`default_nettype wire

// File: source/dma_frontend_top.sv
//------------------------------
// DMA front end top level
// accelerator port in, wishbone classic master out
//------------------------------
`default_nettype none

module dma_frontend_top import dma_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    input  wire acc_req_t acc_req_i,
    input  wire logic     acc_req_valid_i,
    output logic          acc_req_ready_o,
    output acc_rsp_t      acc_rsp_o,
    output logic          acc_rsp_valid_o,
    input  wire logic     acc_rsp_ready_i,
    output wb_m2s_t       wb_m2s_o,
    input  wire wb_s2m_t  wb_s2m_i
);

    logic     wr_src, wr_dst, wr_str, wr_rep, issue, retire;
    data_t    arg_a, arg_b;
    dma_job_t cfg, dec_job, eng_job;
    tf_id_t   next_id, completed_id;
    logic     job_valid, job_ready, eng_valid, eng_ready;
    logic     fifo_empty, eng_busy;
    acc_rsp_t dec_rsp;
    logic     dec_rsp_valid, dec_rsp_ready;

    dma_cfg_regs u_cfg_regs (
        .clk_i, .rst_n_i,
        .wr_src_i (wr_src), .wr_dst_i (wr_dst), .wr_str_i (wr_str), .wr_rep_i (wr_rep),
        .arg_a_i (arg_a), .arg_b_i (arg_b), .issue_i (issue), .retire_i (retire),
        .cfg_o (cfg), .next_id_o (next_id), .completed_id_o (completed_id)
    );

    dma_inst_decode u_decode (
        .acc_req_i, .acc_req_valid_i, .acc_req_ready_o,
        .cfg_i (cfg), .next_id_i (next_id), .completed_id_i (completed_id),
        .busy_i (eng_busy || !fifo_empty), .job_ready_i (job_ready),
        .rsp_ready_i (dec_rsp_ready),
        .wr_src_o (wr_src), .wr_dst_o (wr_dst), .wr_str_o (wr_str), .wr_rep_o (wr_rep),
        .arg_a_o (arg_a), .arg_b_o (arg_b), .issue_o (issue),
        .job_o (dec_job), .job_valid_o (job_valid),
        .rsp_o (dec_rsp), .rsp_valid_o (dec_rsp_valid)
    );

    dma_job_fifo u_job_fifo (
        .clk_i, .rst_n_i,
        .push_i (dec_job), .push_valid_i (job_valid), .push_ready_o (job_ready),
        .pop_o (eng_job), .pop_valid_o (eng_valid), .pop_ready_i (eng_ready),
        .empty_o (fifo_empty)
    );

    dma_copy_engine u_engine (
        .clk_i, .rst_n_i,
        .job_i (eng_job), .job_valid_i (eng_valid), .job_ready_o (eng_ready),
        .wb_m2s_o, .wb_s2m_i, .retire_o (retire), .busy_o (eng_busy)
    );

    dma_rsp_skid u_rsp_skid (
        .clk_i, .rst_n_i,
        .in_i (dec_rsp), .in_valid_i (dec_rsp_valid), .in_ready_o (dec_rsp_ready),
        .out_o (acc_rsp_o), .out_valid_o (acc_rsp_valid_o), .out_ready_i (acc_rsp_ready_i)
    );

endmodule

`default_nettype wire

// File: test/tb_wb_mem.sv
//------------------------------
// wishbone classic memory model for the testbench
// 4 KiB of words filled from a galois LFSR
// acks one cycle after stb
//------------------------------
`default_nettype none

module tb_wb_mem import dma_pkg::*; (
    input  wire logic    clk_i,
    input  wire logic    rst_n_i,
    input  wire logic    ack_hold_i,
    input  wire wb_m2s_t wb_m2s_i,
    output wb_s2m_t      wb_s2m_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned WORDS = 1024;
    localparam logic [15:0] SEED  = 16'd25245;

    data_t      mem_q [WORDS];
    logic       ack_q;
    data_t      dat_q;
    logic [9:0] idx;
    logic       take;

    // one galois step over the taps of a maximal 16-bit polynomial
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) next = next ^ 16'hB400;
        return next;
    endfunction

    // one LFSR step per data bit
    initial begin
        logic [15:0] state;
        data_t       word;
        state = SEED;
        for (int i = 0; i < WORDS; i++) begin
            for (int b = 0; b < 32; b++) begin
                state   = lfsr_step(state);
                word[b] = state[0];
            end
            mem_q[i] <= word;
        end
    end

    assign idx  = wb_m2s_i.adr[11:2];
    assign take = wb_m2s_i.cyc && wb_m2s_i.stb && !ack_q && !ack_hold_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
            dat_q <= '0;
        end else begin
            ack_q <= take;
            if (take) dat_q <= mem_q[idx];
        end
    end

    always @(posedge clk_i) begin
        if (take && wb_m2s_i.we) mem_q[idx] <= wb_m2s_i.dat;
    end

    assign wb_s2m_o = '{ack: ack_q, dat: dat_q};

endmodule

`default_nettype wire

// File: test/tb_dma_frontend.sv
//------------------------------
// testbench for the DMA front end
// directed tests over the accelerator port
// memory checked against a shadow copy of the wishbone memory model
//------------------------------
`default_nettype none

module tb_dma_frontend import dma_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    // per-test bounds in clock cycles
    localparam int T1_CYCLES    = 100;
    localparam int T2_CYCLES    = 500;
    localparam int T3_CYCLES    = 1200;
    localparam int T4_CYCLES    = 200;
    localparam int T5_CYCLES    = 1200;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                                   + T4_CYCLES + T5_CYCLES) * CLK_PERIOD;

    logic     clk;
    logic     rst_n;
    acc_req_t acc_req;
    logic     acc_req_valid;
    logic     acc_req_ready;
    acc_rsp_t acc_rsp;
    logic     acc_rsp_valid;
    logic     acc_rsp_ready;
    wb_m2s_t  wb_m2s;
    wb_s2m_t  wb_s2m;
    logic     ack_hold;

    int       err_count   = 0;
    int       check_count = 0;
    int       bus_cycles  = 0;
    tf_id_t   exp_next_id;
    data_t    shadow [1024];

    dma_frontend_top u_dut (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .acc_req_i       (acc_req),
        .acc_req_valid_i (acc_req_valid),
        .acc_req_ready_o (acc_req_ready),
        .acc_rsp_o       (acc_rsp),
        .acc_rsp_valid_o (acc_rsp_valid),
        .acc_rsp_ready_i (acc_rsp_ready),
        .wb_m2s_o        (wb_m2s),
        .wb_s2m_i        (wb_s2m)
    );

    tb_wb_mem u_mem (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .ack_hold_i (ack_hold),
        .wb_m2s_i   (wb_m2s),
        .wb_s2m_o   (wb_s2m)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // cycles with a bus cycle open
    always @(posedge clk) begin
        if (wb_m2s.cyc) bus_cycles <= bus_cycles + 1;
    end

    // every access is a single full word
    always @(negedge clk) begin
        if (wb_m2s.cyc && wb_m2s.sel !== '1) begin
            err_count++;
            $display("[FAIL] %0t wb sel: got %b expected %b", $time, wb_m2s.sel, 4'hF);
        end
    end

    //------------------------------
    // checks
    //------------------------------
    task automatic report_error(input string what);
        err_count++;
        $display("%0t: %s", $time, what);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %0t %s: got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_rsp(input string name, input acc_rsp_t got, input acc_rsp_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %0t %s: got tag %0d data %h err %b expected tag %0d data %h err %b",
                     $time, name, got.tag, got.data, got.error, exp.tag, exp.data, exp.error);
        end
    endtask

    //------------------------------
    // request and response handling
    //------------------------------
    function automatic acc_req_t make_req(input tag_t tag, input dma_op_e op,
                                          input data_t a, input data_t b);
        acc_req_t req;
        req.tag   = tag;
        req.op    = op;
        req.arg_a = a;
        req.arg_b = b;
        return req;
    endfunction

    function automatic acc_rsp_t make_rsp(input tag_t tag, input data_t data, input logic err);
        acc_rsp_t rsp;
        rsp.tag   = tag;
        rsp.data  = data;
        rsp.error = err;
        return rsp;
    endfunction

    task automatic drive_req(input acc_req_t req);
        @(posedge clk);
        acc_req       <= req;
        acc_req_valid <= 1'b1;
    endtask

    // ends on the edge that takes the request
    task automatic wait_accept(input int limit);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!acc_req_ready && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (!acc_req_ready) report_error($sformatf("request not accepted in %0d cycles", limit));
        @(posedge clk);
        acc_req_valid <= 1'b0;
    endtask

    task automatic send_req(input acc_req_t req);
        drive_req(req);
        wait_accept(20);
    endtask

    task automatic recv_rsp(output acc_rsp_t rsp, input int limit);
        int waited;
        waited = 0;
        rsp    = '0;
        @(negedge clk);
        while (!acc_rsp_valid && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (!acc_rsp_valid) begin
            report_error($sformatf("no response within %0d cycles", limit));
        end else begin
            rsp = acc_rsp;
            @(posedge clk);
        end
    endtask

    // response due exactly one cycle after acceptance
    task automatic request_response(input acc_req_t req, output acc_rsp_t rsp);
        send_req(req);
        recv_rsp(rsp, 0);
    endtask

    task automatic issue_copy(input tag_t tag, input rep_t len, input data_t arg_b);
        acc_rsp_t rsp;
        request_response(make_req(tag, OP_CPY, len, arg_b), rsp);
        check_rsp("copy response", rsp, make_rsp(tag, exp_next_id, 1'b0));
        exp_next_id++;
    endtask

    task automatic wait_done(input tf_id_t id);
        acc_rsp_t rsp;
        int       polls;
        polls = 0;
        rsp   = '0;
        while (polls < 150) begin
            request_response(make_req(5'd31, OP_STAT, 32'd0, 32'd0), rsp);
            if (rsp.data == id) break;
            polls++;
        end
        if (rsp.data != id) report_error($sformatf("transfer %0d never completed", id));
    endtask

    //------------------------------
    // shadow memory
    //------------------------------
    task automatic apply_copy(input addr_t src, input addr_t dst, input rep_t len,
                              input rep_t reps, input rep_t sstr, input rep_t dstr);
        addr_t s;
        addr_t d;
        for (rep_t r = 0; r < reps; r++) begin
            for (rep_t k = 0; k < len / 4; k++) begin
                s = src + r * sstr + 4 * k;
                d = dst + r * dstr + 4 * k;
                shadow[d[11:2]] = shadow[s[11:2]];
            end
        end
    endtask

    task automatic verify_memory();
        for (int i = 0; i < 1024; i++) begin
            check_data($sformatf("mem[0x%03h]", i * 4), u_mem.mem_q[i], shadow[i]);
        end
    endtask

    //------------------------------
    // directed tests
    //------------------------------
    task automatic test_reset_state();
        acc_rsp_t rsp;
        @(negedge clk);
        check_flag("acc_rsp_valid_o", acc_rsp_valid, 1'b0);
        check_flag("wb cyc", wb_m2s.cyc, 1'b0);
        request_response(make_req(5'd1, OP_STAT, 32'd0, 32'd0), rsp);
        check_rsp("completed id after reset", rsp, make_rsp(5'd1, 32'd0, 1'b0));
        request_response(make_req(5'd2, OP_STAT, 32'd0, 32'd1), rsp);
        check_rsp("next id after reset", rsp, make_rsp(5'd2, 32'd1, 1'b0));
    endtask

    task automatic test_copy_1d();
        send_req(make_req(5'd3, OP_SRC, 32'h100, 32'd0));
        send_req(make_req(5'd3, OP_DST, 32'h800, 32'd0));
        issue_copy(5'd4, 32'd16, 32'd0);
        wait_done(exp_next_id - 1);
        apply_copy(32'h100, 32'h800, 32'd16, 32'd1, 32'd0, 32'd0);
        verify_memory();
    endtask

    task automatic test_copy_2d();
        send_req(make_req(5'd5, OP_SRC, 32'h200, 32'd0));
        send_req(make_req(5'd5, OP_DST, 32'h900, 32'd0));
        send_req(make_req(5'd5, OP_STR, 32'h20, 32'h40));
        send_req(make_req(5'd5, OP_REP, 32'd3, 32'd0));
        issue_copy(5'd6, 32'd8, 32'd2);
        wait_done(exp_next_id - 1);
        apply_copy(32'h200, 32'h900, 32'd8, 32'd3, 32'h20, 32'h40);
        verify_memory();
        // bit 1 clear copies one row although reps stays 3
        send_req(make_req(5'd7, OP_DST, 32'hA00, 32'd0));
        issue_copy(5'd8, 32'd8, 32'd0);
        wait_done(exp_next_id - 1);
        apply_copy(32'h200, 32'hA00, 32'd8, 32'd1, 32'h20, 32'h40);
        verify_memory();
    endtask

    task automatic test_rsp_order();
        acc_rsp_t r0;
        acc_rsp_t r1;
        acc_rsp_t r2;
        logic     stalled;
        @(posedge clk);
        acc_rsp_ready <= 1'b0;
        send_req(make_req(5'd10, OP_STAT, 32'd0, 32'd0));
        send_req(make_req(5'd11, OP_STAT, 32'd0, 32'd1));
        drive_req(make_req(5'd12, OP_STAT, 32'd0, 32'd2));
        stalled = 1'b1;
        repeat (4) begin
            @(negedge clk);
            if (acc_req_ready) stalled = 1'b0;
        end
        check_flag("third request stalled", stalled, 1'b1);
        @(posedge clk);
        acc_rsp_ready <= 1'b1;
        fork
            wait_accept(10);
            begin
                recv_rsp(r0, 10);
                recv_rsp(r1, 10);
                recv_rsp(r2, 10);
            end
        join
        check_rsp("first response", r0, make_rsp(5'd10, exp_next_id - 1, 1'b0));
        check_rsp("second response", r1, make_rsp(5'd11, exp_next_id, 1'b0));
        check_rsp("third response", r2, make_rsp(5'd12, 32'd0, 1'b0));
    endtask

    task automatic test_queue_full();
        acc_rsp_t rsp;
        int       cycles_before;
        @(posedge clk);
        ack_hold <= 1'b1;
        // one job stuck in the engine, three waiting in the queue
        for (int i = 0; i < 4; i++) begin
            send_req(make_req(5'd20, OP_SRC, 32'h300 + 4 * i, 32'd0));
            send_req(make_req(5'd20, OP_DST, 32'hB00 + 32'h10 * i, 32'd0));
            issue_copy(tag_t'(21 + i), 32'd4, 32'd0);
        end
        request_response(make_req(5'd25, OP_STAT, 32'd0, 32'd3), rsp);
        check_rsp("queue full status", rsp, make_rsp(5'd25, 32'd1, 1'b0));
        request_response(make_req(5'd26, OP_STAT, 32'd0, 32'd2), rsp);
        check_rsp("busy status", rsp, make_rsp(5'd26, 32'd1, 1'b0));
        @(posedge clk);
        ack_hold <= 1'b0;
        wait_done(exp_next_id - 1);
        for (int i = 0; i < 4; i++) begin
            apply_copy(32'h300 + 4 * i, 32'hB00 + 32'h10 * i, 32'd4, 32'd1, 32'd0, 32'd0);
        end
        verify_memory();
        request_response(make_req(5'd27, dma_op_e'(3'd6), 32'd0, 32'd0), rsp);
        check_rsp("unknown op response", rsp, make_rsp(5'd27, 32'd0, 1'b1));
        cycles_before = bus_cycles;
        issue_copy(5'd28, 32'd0, 32'd0);
        wait_done(exp_next_id - 1);
        check_data("bus cycles of zero-length copy", data_t'(bus_cycles - cycles_before), 32'd0);
        verify_memory();
    endtask

    //------------------------------
    // run
    //------------------------------
    initial begin
        acc_req       = '0;
        acc_req_valid = 1'b0;
        acc_rsp_ready = 1'b1;
        ack_hold      = 1'b0;
        rst_n         = 1'b0;
        exp_next_id   = 32'd1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < 1024; i++) shadow[i] = u_mem.mem_q[i];
        test_reset_state();
        test_copy_1d();
        test_copy_2d();
        test_rsp_order();
        test_queue_full();
        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+source
source/dma_pkg.sv
source/dma_cfg_regs.sv
source/dma_inst_decode.sv
source/dma_job_fifo.sv
source/dma_copy_engine.sv
source/dma_rsp_skid.sv
source/dma_frontend_top.sv
test/tb_wb_mem.sv
test/tb_dma_frontend.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the DMA front end testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_dma_frontend --Mdir obj_dir -o tb_dma_frontend

output=$(./obj_dir/tb_dma_frontend)
echo "$output"

if grep -qx "ALL TESTS PASSED" <<< "$output"; then
    exit 0
fi
exit 1
